//--- files.f
+incdir+common
common/mc_pkg.sv
common/mc_link_if.sv
verilog/io_ctrl.sv
verilog/io_monitor.sv
verilog/mem_model.sv
verilog/io_complex.sv
test/tb_clkgen.sv
test/tb_io_complex.sv

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run, then look for the fail line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_io_complex \
  -Mdir obj_dir -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  && cat sim.log \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

grep -q "Finished with errors" sim.log && exit 1 || exit 0

//--- test/tb_io_complex.sv
`timescale 1ns/10ps
`include "mc_defines.svh"

module tb_io_complex import mc_pkg::*; ();

  localparam int IO  = `MC_IO_COL;
  localparam int NC  = `MC_NUM_COLS;
  localparam int MAX = `MC_MAX_CYCLES;

  logic                  clk;
  logic                  rst_n;
  logic                  restart;

  logic    [NC-1:0]      io_in_v_i;
  mc_pkt_s [NC-1:0]      io_in_pkt_i;
  logic    [NC-1:0]      io_in_ready_o;
  logic    [NC-1:0]      io_out_v_o;
  mc_pkt_s [NC-1:0]      io_out_pkt_o;
  logic    [NC-1:0]      io_out_ready_i;
  logic    [NC-1:0]      ver_in_v_i;
  mc_pkt_s [NC-1:0]      ver_in_pkt_i;
  logic    [NC-1:0]      ver_in_ready_o;
  logic    [NC-1:0]      ver_out_v_o;
  mc_pkt_s [NC-1:0]      ver_out_pkt_o;
  logic    [NC-1:0]      ver_out_ready_i;
  logic                  start_i;
  logic [`MC_DATA_W-1:0] load_base_i;
  logic [`MC_ADDR_W-1:0] load_count_i;
  logic                  load_done_o;
  logic                  finish_o;
  logic                  success_o;
  logic                  timeout_o;

  // reference model
  mc_pkt_s               exp_q [$];
  int                    cred_m;
  int                    sent_cnt;
  int                    pend_resp;
  logic                  done_seen;
  logic                  v_seen;
  logic [`MC_DATA_W-1:0] mem_m [NC][`MC_MEM_WORDS];
  bit                    written [NC][`MC_MEM_WORDS];

  string                 test_name;
  int                    n_checks;
  int                    n_errors;
  int                    n_tests;
  int                    n_failed;
  int                    err_base;

  tb_clkgen u_clk (.restart_i(restart), .clk_o(clk), .rst_n_o(rst_n));

  io_complex u_dut (.clk_i(clk), .rst_n_i(rst_n), .*);

  task automatic check_bit(input string what, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("[ERROR] %s %s: expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    n_checks++;
    if (act != exp) begin
      n_errors++;
      $display("[ERROR] %s %s: expected %0d actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_op(input string what, input mc_op_e exp, input mc_op_e act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("[ERROR] %s %s: expected %0d actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_pkt(input string what, input mc_pkt_s exp, input mc_pkt_s act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("[ERROR] %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic report_hang(input string what);
    n_errors++;
    $display("[TIMEOUT] %s: %s", test_name, what);
  endtask

  task automatic drive_idle();
    start_i         <= 1'b0;
    load_base_i     <= '0;
    load_count_i    <= '0;
    io_in_v_i       <= '0;
    io_in_pkt_i     <= '0;
    io_out_ready_i  <= '0;
    ver_in_v_i      <= '0;
    ver_in_pkt_i    <= '0;
    ver_out_ready_i <= '0;
  endtask

  // returns at the first falling edge after reset release
  task automatic wait_release();
    int guard;
    guard = 0;
    @(negedge clk);
    while (rst_n !== 1'b1 && guard < 20) begin
      @(negedge clk);
      guard++;
    end
    if (rst_n !== 1'b1) begin
      report_hang("reset was never released");
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    restart <= 1'b1;
    drive_idle();
    @(posedge clk);
    restart <= 1'b0;
    wait_release();
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_base  = n_errors;
    apply_reset();
  endtask

  task automatic end_test();
    n_tests++;
    if (n_errors == err_base) begin
      $display("test %s ok", test_name);
    end else begin
      n_failed++;
      $display("test %s failed with %0d errors", test_name, n_errors - err_base);
    end
  endtask

  task automatic start_load(input logic [`MC_DATA_W-1:0] base,
                            input logic [`MC_ADDR_W-1:0] count);
    mc_pkt_s pkt;
    exp_q.delete();
    for (int k = 0; k < int'(count); k++) begin
      pkt.op   = OP_STORE;
      pkt.addr = `MC_ADDR_W'(k);
      pkt.data = base + `MC_DATA_W'(k);
      pkt.x    = `MC_X_W'(k % NC);
      exp_q.push_back(pkt);
    end
    cred_m    = `MC_CREDITS;
    sent_cnt  = 0;
    pend_resp = 0;
    @(posedge clk);
    load_base_i        <= base;
    load_count_i       <= count;
    start_i            <= 1'b1;
    io_out_ready_i[IO] <= 1'b1;
    @(posedge clk);
    start_i <= 0;
  endtask

  // samples the I/O column at the falling edge and drives it at the rising edge
  task automatic loader_step(input logic ready_nxt, input bit resp_nxt);
    logic    exp_v;
    mc_pkt_s rsp;
    @(negedge clk);
    exp_v     = (exp_q.size() > 0) && (cred_m > 0);
    v_seen    = io_out_v_o[IO];
    done_seen = load_done_o;
    check_bit("io_out_v_o", exp_v, io_out_v_o[IO]);
    for (int c = 0; c < NC; c++) begin
      check_bit("io_in_ready_o", 1'b1, io_in_ready_o[c]);
      if (c != IO) begin
        check_bit("io_out_v_o idle column", 1'b0, io_out_v_o[c]);
      end
    end
    if (io_out_v_o[IO] && exp_q.size() > 0) begin
      check_pkt("offered packet", exp_q[0], io_out_pkt_o[IO]);
      if (io_out_ready_i[IO]) begin
        void'(exp_q.pop_front());
        sent_cnt++;
        cred_m--;
        pend_resp++;
      end
    end
    if (io_in_v_i[IO] && io_in_pkt_i[IO].op == OP_RESP) begin
      cred_m++;
    end
    @(posedge clk);
    io_out_ready_i[IO] <= ready_nxt;
    if (resp_nxt) begin
      rsp.op   = OP_RESP;
      rsp.addr = '0;
      rsp.data = $urandom;
      rsp.x    = `MC_X_W'(IO);
      io_in_v_i[IO]   <= 1'b1;
      io_in_pkt_i[IO] <= rsp;
      if (pend_resp > 0) begin
        pend_resp--;
      end
    end else begin
      io_in_v_i[IO] <= 1'b0;
    end
  endtask

  task automatic run_load(input string name, input bit rand_ready);
    logic [`MC_DATA_W-1:0] base;
    logic [`MC_ADDR_W-1:0] count;
    int                    guard;
    begin_test(name);
    base  = $urandom;
    count = rand_ready ? `MC_ADDR_W'($urandom % 41) : `MC_ADDR_W'(1 + $urandom % 40);
    start_load(base, count);
    done_seen = 1'b0;
    guard     = 0;
    while (!done_seen && guard < 400) begin
      loader_step(rand_ready ? 1'($urandom % 2) : 1'b1, pend_resp > 0);
      guard++;
    end
    if (!done_seen) begin
      report_hang("load_done_o never rose");
    end
    // a few more cycles to catch a stray packet
    repeat (6) loader_step(1'b1, pend_resp > 0);
    check_count("packets sent", int'(count), sent_cnt);
    check_count("packets missing", 0, exp_q.size());
    check_bit("load_done_o", 1'b1, done_seen);
    end_test();
  endtask

  task automatic credit_test();
    begin_test("credit_limit");
    start_load($urandom, `MC_ADDR_W'(20));
    repeat (20) loader_step(1'b1, 1'b0);
    check_count("packets before stall", `MC_CREDITS, sent_cnt);
    check_bit("io_out_v_o after stall", 1'b0, v_seen);
    for (int i = 1; i <= 4; i++) begin
      loader_step(1'b1, 1'b1);
      repeat (4) loader_step(1'b1, 1'b0);
      check_count("packets after response", `MC_CREDITS + i, sent_cnt);
    end
    end_test();
  endtask

  task automatic mem_test();
    mc_pkt_s exp_rsp [NC];
    bit      rsp_wait [NC];
    bit      req_v [NC];
    bit      req_acc [NC];
    mc_pkt_s req;
    int      n_rsp;
    begin_test("memory");
    n_rsp = 0;
    for (int c = 0; c < NC; c++) begin
      rsp_wait[c] = 1'b0;
      req_v[c]    = 1'b0;
      for (int a = 0; a < `MC_MEM_WORDS; a++) begin
        written[c][a] = 1'b0;
      end
    end
    for (int cyc = 0; cyc < 300; cyc++) begin
      @(negedge clk);
      for (int c = 0; c < NC; c++) begin
        check_bit("ver_in_ready_o", !rsp_wait[c], ver_in_ready_o[c]);
        check_bit("ver_out_v_o", rsp_wait[c], ver_out_v_o[c]);
        if (rsp_wait[c] && ver_out_v_o[c]) begin
          check_op("response op", OP_RESP, ver_out_pkt_o[c].op);
          check_pkt("response", exp_rsp[c], ver_out_pkt_o[c]);
          if (ver_out_ready_i[c]) begin
            rsp_wait[c] = 1'b0;
            n_rsp++;
          end
        end
        req_acc[c] = req_v[c] && ver_in_ready_o[c];
        if (req_acc[c]) begin
          req              = ver_in_pkt_i[c];
          exp_rsp[c].op    = OP_RESP;
          exp_rsp[c].addr  = req.addr;
          exp_rsp[c].x     = `MC_X_W'(c);
          if (req.op == OP_STORE) begin
            mem_m[c][req.addr]   = req.data;
            written[c][req.addr] = 1'b1;
          end
          exp_rsp[c].data = mem_m[c][req.addr];
          rsp_wait[c]     = 1'b1;
        end
      end
      @(posedge clk);
      for (int c = 0; c < NC; c++) begin
        ver_out_ready_i[c] <= 1'($urandom % 2);
        // a request stays on the link until it is taken
        if (!req_v[c] || req_acc[c]) begin
          req_v[c] = ($urandom % 2 == 1);
          req.addr = `MC_ADDR_W'($urandom % 16);
          req.op   = (written[c][req.addr] && $urandom % 2 == 1) ? OP_LOAD : OP_STORE;
          req.data = $urandom;
          req.x    = `MC_X_W'(c);
          ver_in_v_i[c]   <= req_v[c];
          ver_in_pkt_i[c] <= req;
        end
      end
    end
    check_bit("responses seen", 1'b1, n_rsp > 0);
    end_test();
  endtask

  task automatic finish_case(input string name, input logic [`MC_ADDR_W-1:0] addr,
                             input logic exp_success);
    int      col;
    int      guard;
    mc_pkt_s pkt;
    begin_test(name);
    col = int'($urandom % NC);
    check_bit("finish_o after reset", 1'b0, finish_o);
    check_bit("success_o after reset", 1'b0, success_o);
    pkt.op   = OP_STORE;
    pkt.addr = addr;
    pkt.data = $urandom;
    pkt.x    = `MC_X_W'(col);
    @(posedge clk);
    io_in_v_i[col]   <= 1'b1;
    io_in_pkt_i[col] <= pkt;
    @(posedge clk);
    io_in_v_i[col] <= 1'b0;
    guard = 0;
    @(negedge clk);
    while (!finish_o && guard < 10) begin
      @(negedge clk);
      guard++;
    end
    if (!finish_o) begin
      report_hang("finish_o never rose");
    end
    check_bit("success_o", exp_success, success_o);
    repeat (5) @(negedge clk);
    check_bit("finish_o held", 1'b1, finish_o);
    check_bit("success_o held", exp_success, success_o);
    end_test();
  endtask

  task automatic timeout_test();
    int guard;
    begin_test("timeout");
    repeat (MAX - 2) @(negedge clk);
    check_bit("timeout_o early", 1'b0, timeout_o);
    guard = MAX - 2;
    while (!timeout_o && guard < MAX + 2) begin
      @(negedge clk);
      guard++;
    end
    check_bit("timeout_o", 1'b1, timeout_o);
    check_bit("finish_o", 1'b0, finish_o);
    end_test();
  endtask

  initial begin
    void'($urandom(90));
    restart <= 1'b0;
    drive_idle();
    n_checks  = 0;
    n_errors  = 0;
    n_tests   = 0;
    n_failed  = 0;
    test_name = "reset";
    wait_release();
    run_load("loader_stream", 1'b0);
    credit_test();
    run_load("back_pressure", 1'b1);
    mem_test();
    finish_case("finish_store", `MC_FINISH_ADDR, 1'b1);
    finish_case("fail_store", `MC_FAIL_ADDR, 1'b0);
    timeout_test();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             n_tests, n_failed, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- test/tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen (
  input  logic restart_i,
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #5 clk_o = ~clk_o;
    end
  end

  // low for 4 rising edges at start, again after each restart request
  initial begin
    rst_n_o <= 1'b0;
    forever begin
      repeat (4) @(posedge clk_o);
      rst_n_o <= 1'b1;
      @(posedge restart_i);
      rst_n_o <= 1'b0;
    end
  end

endmodule

//--- verilog/io_complex.sv
`timescale 1ns/10ps
`include "mc_defines.svh"

module io_complex import mc_pkg::*; (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,

  input  logic    [`MC_NUM_COLS-1:0]           io_in_v_i,
  input  mc_pkt_s [`MC_NUM_COLS-1:0]           io_in_pkt_i,
  output logic    [`MC_NUM_COLS-1:0]           io_in_ready_o,
  output logic    [`MC_NUM_COLS-1:0]           io_out_v_o,
  output mc_pkt_s [`MC_NUM_COLS-1:0]           io_out_pkt_o,
  input  logic    [`MC_NUM_COLS-1:0]           io_out_ready_i,

  input  logic    [`MC_NUM_COLS-1:0]           ver_in_v_i,
  input  mc_pkt_s [`MC_NUM_COLS-1:0]           ver_in_pkt_i,
  output logic    [`MC_NUM_COLS-1:0]           ver_in_ready_o,
  output logic    [`MC_NUM_COLS-1:0]           ver_out_v_o,
  output mc_pkt_s [`MC_NUM_COLS-1:0]           ver_out_pkt_o,
  input  logic    [`MC_NUM_COLS-1:0]           ver_out_ready_i,

  input  logic                                 start_i,
  input  logic    [`MC_DATA_W-1:0]             load_base_i,
  input  logic    [`MC_ADDR_W-1:0]             load_count_i,

  output logic                                 load_done_o,
  output logic                                 finish_o,
  output logic                                 success_o,
  output logic                                 timeout_o
);

  logic [`MC_NUM_COLS-1:0] col_finish;
  logic [`MC_NUM_COLS-1:0] col_success;

  // one loader link per column, only the I/O column carries traffic
  mc_link_if ld_link [`MC_NUM_COLS] ();

  io_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .start_i       (start_i),
    .load_base_i   (load_base_i),
    .load_count_i  (load_count_i),
    .col_finish_i  (col_finish),
    .col_success_i (col_success),
    .ld_o          (ld_link[`MC_IO_COL]),
    .load_done_o   (load_done_o),
    .finish_o      (finish_o),
    .success_o     (success_o),
    .timeout_o     (timeout_o)
  );

  for (genvar g = 0; g < `MC_NUM_COLS; g++) begin : g_col
    if (g != `MC_IO_COL) begin : g_tie
      assign ld_link[g].v   = 1'b0;
      assign ld_link[g].pkt = '0;
    end

    io_monitor #(
      .PASS_THRU (g == `MC_IO_COL)
    ) u_mon (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .ld_i           (ld_link[g]),
      .io_in_v_i      (io_in_v_i[g]),
      .io_in_pkt_i    (io_in_pkt_i[g]),
      .io_in_ready_o  (io_in_ready_o[g]),
      .io_out_v_o     (io_out_v_o[g]),
      .io_out_pkt_o   (io_out_pkt_o[g]),
      .io_out_ready_i (io_out_ready_i[g]),
      .finish_o       (col_finish[g]),
      .success_o      (col_success[g])
    );

    mem_model u_mem (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .my_x_i          (`MC_X_W'(g)),
      .ver_in_v_i      (ver_in_v_i[g]),
      .ver_in_pkt_i    (ver_in_pkt_i[g]),
      .ver_in_ready_o  (ver_in_ready_o[g]),
      .ver_out_v_o     (ver_out_v_o[g]),
      .ver_out_pkt_o   (ver_out_pkt_o[g]),
      .ver_out_ready_i (ver_out_ready_i[g])
    );
  end

endmodule

//--- verilog/mem_model.sv
`timescale 1ns/10ps
`include "mc_defines.svh"

module mem_model import mc_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic [`MC_X_W-1:0] my_x_i,
  input  logic               ver_in_v_i,
  input  mc_pkt_s            ver_in_pkt_i,
  output logic               ver_in_ready_o,
  output logic               ver_out_v_o,
  output mc_pkt_s            ver_out_pkt_o,
  input  logic               ver_out_ready_i
);

  logic [`MC_DATA_W-1:0] mem [`MC_MEM_WORDS];
  mc_pkt_s               resp_q;
  logic                  resp_v_q;
  logic                  acc;
  logic                  is_store;

  // single entry, no new request while a response waits
  assign ver_in_ready_o = !resp_v_q;
  assign acc            = ver_in_v_i && ver_in_ready_o;
  assign is_store       = (ver_in_pkt_i.op == OP_STORE);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_v_q <= 1'b0;
    end else if (acc) begin
      resp_v_q <= 1'b1;
    end else if (ver_out_ready_i) begin
      resp_v_q <= 1'b0;
    end
  end

  // store response echoes the written data
  always_ff @(posedge clk_i) begin
    if (acc) begin
      if (is_store) begin
        mem[ver_in_pkt_i.addr] <= ver_in_pkt_i.data;
      end
      resp_q.op   <= OP_RESP;
      resp_q.addr <= ver_in_pkt_i.addr;
      resp_q.data <= is_store ? ver_in_pkt_i.data : mem[ver_in_pkt_i.addr];
      resp_q.x    <= my_x_i;
    end
  end

  assign ver_out_v_o   = resp_v_q;
  assign ver_out_pkt_o = resp_q;

  a_no_resp_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acc |-> ver_in_pkt_i.op != OP_RESP);

endmodule

//--- verilog/io_monitor.sv
`timescale 1ns/10ps
`include "mc_defines.svh"

module io_monitor import mc_pkg::*; #(
  parameter bit PASS_THRU = 1'b0
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  mc_link_if.dst  ld_i,
  input  logic    io_in_v_i,
  input  mc_pkt_s io_in_pkt_i,
  output logic    io_in_ready_o,
  output logic    io_out_v_o,
  output mc_pkt_s io_out_pkt_o,
  input  logic    io_out_ready_i,
  output logic    finish_o,
  output logic    success_o
);

  logic st_in;

  // the monitor sinks every packet from the tile side
  assign io_in_ready_o = 1'b1;
  assign st_in         = io_in_v_i && (io_in_pkt_i.op == OP_STORE);

  assign io_out_pkt_o = ld_i.pkt;

  if (PASS_THRU) begin : g_pass
    logic [`MC_CRED_W-1:0] cred_q;
    logic                  has_cred;
    logic                  send;
    logic                  resp_in;

    assign has_cred = (cred_q != '0);
    assign send     = ld_i.v && ld_i.ready;
    assign resp_in  = io_in_v_i && (io_in_pkt_i.op == OP_RESP);

    // loader packet goes straight out, no added cycle
    assign ld_i.ready = io_out_ready_i && has_cred;
    assign io_out_v_o = ld_i.v && has_cred;

    // one credit per packet out, one back per response in
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        cred_q <= `MC_CRED_W'(`MC_CREDITS);
      end else if (send && !resp_in) begin
        cred_q <= cred_q - 1'b1;
      end else if (resp_in && !send) begin
        cred_q <= cred_q + 1'b1;
      end
    end

    a_cred_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cred_q <= `MC_CRED_W'(`MC_CREDITS));
  end else begin : g_term
    assign ld_i.ready = 1'b0;
    assign io_out_v_o = 1'b0;
  end

  // finish and fail stores, flags stick until reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      finish_o  <= 1'b0;
      success_o <= 1'b0;
    end else if (st_in) begin
      if (io_in_pkt_i.addr == `MC_FINISH_ADDR) begin
        finish_o  <= 1'b1;
        success_o <= 1'b1;
      end else if (io_in_pkt_i.addr == `MC_FAIL_ADDR) begin
        finish_o <= 1'b1;
      end
    end
  end

endmodule

//--- verilog/io_ctrl.sv
`timescale 1ns/10ps
`include "mc_defines.svh"

module io_ctrl import mc_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    start_i,
  input  logic [`MC_DATA_W-1:0]   load_base_i,
  input  logic [`MC_ADDR_W-1:0]   load_count_i,
  input  logic [`MC_NUM_COLS-1:0] col_finish_i,
  input  logic [`MC_NUM_COLS-1:0] col_success_i,
  mc_link_if.src                  ld_o,
  output logic                    load_done_o,
  output logic                    finish_o,
  output logic                    success_o,
  output logic                    timeout_o
);

  ld_state_e             state_q;
  ld_state_e             state_d;
  logic [`MC_ADDR_W-1:0] idx_q;
  logic [`MC_ADDR_W-1:0] count_q;
  logic [`MC_DATA_W-1:0] base_q;
  logic [`MC_CNT_W-1:0]  cyc_q;
  logic                  xfer;
  logic                  last;
  logic                  fin_any;

  assign xfer = ld_o.v && ld_o.ready;
  assign last = (idx_q == count_q - 1'b1);

  always_comb begin
    state_d = state_q;
    case (state_q)
      LD_IDLE: begin
        if (start_i) begin
          state_d = (load_count_i == '0) ? LD_DONE : LD_SEND;
        end
      end
      LD_SEND: begin
        if (xfer && last) begin
          state_d = LD_DONE;
        end
      end
      default: begin
        state_d = state_q;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= LD_IDLE;
      idx_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == LD_IDLE) begin
        idx_q <= '0;
      end else if (xfer) begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  // run parameters captured at start
  always_ff @(posedge clk_i) begin
    if (state_q == LD_IDLE && start_i) begin
      base_q  <= load_base_i;
      count_q <= load_count_i;
    end
  end

  // store k goes to column k mod MC_NUM_COLS
  assign ld_o.v   = (state_q == LD_SEND);
  assign ld_o.pkt = '{op:   OP_STORE,
                      addr: idx_q,
                      data: base_q + `MC_DATA_W'(idx_q),
                      x:    `MC_X_W'(idx_q % `MC_NUM_COLS)};

  assign load_done_o = (state_q == LD_DONE);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cyc_q <= '0;
    end else if (cyc_q != `MC_CNT_W'(`MC_MAX_CYCLES)) begin
      cyc_q <= cyc_q + 1'b1;
    end
  end

  assign fin_any = |col_finish_i;

  // timeout only if no column flags finish, so the two cannot rise together
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      finish_o  <= 1'b0;
      success_o <= 1'b0;
      timeout_o <= 1'b0;
    end else begin
      finish_o  <= finish_o | fin_any;
      success_o <= success_o | (|col_success_i);
      if (cyc_q == `MC_CNT_W'(`MC_MAX_CYCLES) && !finish_o && !fin_any) begin
        timeout_o <= 1'b1;
      end
    end
  end

  a_ld_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ld_o.v && !ld_o.ready |=> ld_o.v && $stable(ld_o.pkt));

  a_fin_tmo: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !($rose(timeout_o) && $rose(finish_o)));

endmodule

//--- common/mc_link_if.sv
`timescale 1ns/10ps

// valid/ready packet link, a packet moves on an edge with v and ready high
interface mc_link_if import mc_pkg::*; ();

  logic    v;
  logic    ready;
  mc_pkt_s pkt;

  // source holds v and pkt until the transfer
  modport src (
    output v,
    output pkt,
    input  ready
  );

  modport dst (
    input  v,
    input  pkt,
    output ready
  );

endinterface

//--- common/mc_pkg.sv
`include "mc_defines.svh"

package mc_pkg;

  // packet opcodes on every link
  typedef enum logic [1:0] {
    OP_LOAD  = 2'd0,
    OP_STORE = 2'd1,
    OP_RESP  = 2'd2
  } mc_op_e;

  // x is the destination column of a request, the source column of a response
  typedef struct packed {
    mc_op_e                op;
    logic [`MC_ADDR_W-1:0] addr;
    logic [`MC_DATA_W-1:0] data;
    logic [`MC_X_W-1:0]    x;
  } mc_pkt_s;

  // program loader sequencing
  typedef enum logic [1:0] {
    LD_IDLE = 2'd0,
    LD_SEND = 2'd1,
    LD_DONE = 2'd2
  } ld_state_e;

endpackage

//--- common/mc_defines.svh
`ifndef MC_DEFINES_SVH
`define MC_DEFINES_SVH

// mesh geometry
`define MC_NUM_COLS    2
`define MC_IO_COL      1
`define MC_X_W         1

// packet fields
`define MC_ADDR_W      8
`define MC_DATA_W      32

// loader flow control, counter wide enough to hold MC_CREDITS
`define MC_CREDITS     8
`define MC_CRED_W      4

// run control
`define MC_CNT_W       16
`define MC_MAX_CYCLES  2000
`define MC_FINISH_ADDR 8'hF0
`define MC_FAIL_ADDR   8'hF1

`define MC_MEM_WORDS   256

`endif
